/* stereo_patterns.hex */
// one record per word: kind, plus pixel or command byte, minus pixel, expected byte
// kind 00 idle, 01 pixel, 02 sof pixel, 03 command byte

// reset coefficients, depth is the plus pixel
02109910 01207720 01FF00FF 01003300
017F807F 01A5C3A5
00000000 00000000 00000000 00000000

// w_plus 2
03000000 03100000 03000000 03000000 03000000 03020000
// w_minus 1
03000000 03110000 03000000 03000000 03000000 03010000
// shift 1
03000000 03120000 03000000 03000000 03000000 03010000
// offset 10
03000000 03130000 03000000 03000000 03000000 030A0000
00000000 00000000 00000000 00000000

// blended frame, both clamp limits inside
0240203A 01801082 0100FF00 01FF00FF
01103002 0105000F 01C864A0 010A1E05
00000000 00000000 00000000 00000000

// address 0x0020 is not a coefficient
03000000 03200000 03120000 03340000 03560000 03780000
00000000 00000000 00000000 00000000

// sof after three pixels opens a new frame
02301032 0160404A 01221123
02505032 0190A04A 0101020A 01E000EA
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000

/* sim.f */
+incdir+.
stereo_pkg.sv
pipeline_ifs.sv
pixel_input.sv
command_decoder.sv
disparity_blend.sv
frame_packer.sv
stereo_preview_top.sv
tb_stereo_preview.sv

/* run_sim.sh */
#!/bin/sh
# build and run the stereo previewer testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_stereo_preview -f sim.f

sim_out=$(./obj_dir/Vtb_stereo_preview 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
exit 1

/* tb_stereo_preview.sv */
`timescale 1ns/1ps
`default_nettype none

`include "stereo_config.svh"

module tb_stereo_preview;

    localparam int MAX_RECORDS = 256;
    localparam int ROI_PIXELS  = `STEREO_ROI_WIDTH * `STEREO_ROI_HEIGHT;
    localparam int QUIET_LIMIT = 20;

    // frame header on the host link, BIVFRAME
    localparam logic [7:0] HEADER [`STEREO_HEADER_BYTES] = '{
        8'h42, 8'h49, 8'h56, 8'h46, 8'h52, 8'h41, 8'h4D, 8'h45
    };

    // record kinds in the pattern file
    localparam logic [7:0] KIND_IDLE  = 8'h00;
    localparam logic [7:0] KIND_PIXEL = 8'h01;
    localparam logic [7:0] KIND_SOF   = 8'h02;
    localparam logic [7:0] KIND_CMD   = 8'h03;
    localparam logic [7:0] KIND_END   = 8'hFF;

    logic       core_clk;
    logic       sys_reset;
    logic [7:0] cam_plus_d_i;
    logic [7:0] cam_minus_d_i;
    logic       cam_valid_i;
    logic       cam_sof_i;
    logic [7:0] cmd_byte_i;
    logic       cmd_valid_i;
    logic [7:0] tx_byte_o;
    logic       tx_valid_o;
    logic       overflow_o;

    logic [31:0] patterns [MAX_RECORDS];
    logic [7:0]  expected_q [$];
    int          record_count;
    int          timeout_limit;
    int          cycle_count;
    int          pixel_pos;
    int          bytes_seen;

    stereo_preview_top dut (
        .core_clk      (core_clk),
        .sys_reset     (sys_reset),
        .cam_plus_d_i  (cam_plus_d_i),
        .cam_minus_d_i (cam_minus_d_i),
        .cam_valid_i   (cam_valid_i),
        .cam_sof_i     (cam_sof_i),
        .cmd_byte_i    (cmd_byte_i),
        .cmd_valid_i   (cmd_valid_i),
        .tx_byte_o     (tx_byte_o),
        .tx_valid_o    (tx_valid_o),
        .overflow_o    (overflow_o)
    );

    always #50 core_clk = ~core_clk;

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            stop_with_failure($sformatf("FAILED at %0t ns: %s, got 0x%0h, expected 0x%0h",
                                        $time, what, actual, expected));
        end
    endtask

    task automatic drive_cycle(input logic cam_valid, input logic cam_sof,
                               input logic [7:0] plus_px, input logic [7:0] minus_px,
                               input logic cmd_valid, input logic [7:0] cmd_byte);
        @(posedge core_clk);
        cam_valid_i   <= cam_valid;
        cam_sof_i     <= cam_sof;
        cam_plus_d_i  <= plus_px;
        cam_minus_d_i <= minus_px;
        cmd_valid_i   <= cmd_valid;
        cmd_byte_i    <= cmd_byte;
    endtask

    // roi position model, a frame opens with the magic header
    task automatic expect_pixel(input logic sof, input logic [7:0] value);
        int k;
        if (sof) begin
            pixel_pos = 0;
        end
        if (pixel_pos == 0) begin
            for (k = 0; k < `STEREO_HEADER_BYTES; k++) begin
                expected_q.push_back(HEADER[k]);
            end
        end
        expected_q.push_back(value);
        pixel_pos = (pixel_pos + 1) % ROI_PIXELS;
    endtask

    task automatic run_record(input logic [31:0] rec);
        logic [7:0] kind;
        kind = rec[31:24];
        case (kind)
            KIND_IDLE: drive_cycle(1'b0, 1'b0, 8'h00, 8'h00, 1'b0, 8'h00);
            KIND_PIXEL, KIND_SOF: begin
                expect_pixel(kind == KIND_SOF, rec[7:0]);
                drive_cycle(1'b1, kind == KIND_SOF, rec[23:16], rec[15:8], 1'b0, 8'h00);
                // gap cycle, no back-pressure on the packer
                drive_cycle(1'b0, 1'b0, 8'h00, 8'h00, 1'b0, 8'h00);
            end
            KIND_CMD: drive_cycle(1'b0, 1'b0, 8'h00, 8'h00, 1'b1, rec[23:16]);
            default: stop_with_failure($sformatf("pattern record has unknown kind 0x%0h", kind));
        endcase
    endtask

    ////////////////////////////////////////////////////////////////////////
    // output monitor and timeout

    always @(negedge core_clk) begin
        logic [7:0] want;
        if (!sys_reset && tx_valid_o) begin
            if (expected_q.size() == 0) begin
                stop_with_failure($sformatf("byte 0x%0h came out with no byte left to expect",
                                            tx_byte_o));
            end else begin
                want = expected_q.pop_front();
                check_value(32'(tx_byte_o), 32'(want), $sformatf("output byte %0d", bytes_seen));
                bytes_seen = bytes_seen + 1;
            end
        end
    end

    always @(posedge core_clk) begin
        cycle_count = cycle_count + 1;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            stop_with_failure($sformatf("timeout after %0d cycles, the output stream stalled",
                                        cycle_count));
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // stimulus

    initial begin
        int i;
        int quiet_cycles;
        core_clk      = 1'b0;
        sys_reset     = 1'b1;
        cam_plus_d_i  = 8'h00;
        cam_minus_d_i = 8'h00;
        cam_valid_i   = 1'b0;
        cam_sof_i     = 1'b0;
        cmd_byte_i    = 8'h00;
        cmd_valid_i   = 1'b0;
        cycle_count   = 0;
        timeout_limit = 0;
        pixel_pos     = 0;
        bytes_seen    = 0;

        for (i = 0; i < MAX_RECORDS; i++) begin
            patterns[i] = {KIND_END, 24'(i)};
        end
        $readmemh("stereo_patterns.hex", patterns);
        record_count = 0;
        while (record_count < MAX_RECORDS && patterns[record_count][31:24] != KIND_END) begin
            record_count = record_count + 1;
        end
        if (record_count == 0) begin
            stop_with_failure("no records could be read from stereo_patterns.hex");
        end
        timeout_limit = 4 * record_count + 200;

        repeat (8) @(posedge core_clk);
        sys_reset <= 1'b0;

        for (i = 0; i < record_count; i++) begin
            run_record(patterns[i]);
        end
        drive_cycle(1'b0, 1'b0, 8'h00, 8'h00, 1'b0, 8'h00);

        // run until the link has gone quiet, strays still hit the monitor
        quiet_cycles = 0;
        while (quiet_cycles < QUIET_LIMIT) begin
            @(negedge core_clk);
            if (tx_valid_o) begin
                quiet_cycles = 0;
            end else begin
                quiet_cycles = quiet_cycles + 1;
            end
        end

        check_value(32'(overflow_o), 32'd0, "overflow flag at end of run");
        check_value(32'(expected_q.size()), 32'd0, "bytes still expected");
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* stereo_preview_top.sv */
`timescale 1ns/1ps
`default_nettype none

module stereo_preview_top (
    input  logic               core_clk,
    input  logic               sys_reset,

    // lockstep camera pair
    input  stereo_pkg::pixel_t cam_plus_d_i,
    input  stereo_pkg::pixel_t cam_minus_d_i,
    input  logic               cam_valid_i,
    input  logic               cam_sof_i,

    // host command bytes
    input  stereo_pkg::pixel_t cmd_byte_i,
    input  logic               cmd_valid_i,

    // framed byte stream to the host
    output stereo_pkg::pixel_t tx_byte_o,
    output logic               tx_valid_o,
    output logic               overflow_o
);

    pixel_pair_if   pix_bus ();
    depth_stream_if depth_bus ();
    blend_coeff_if  coeff_bus ();

    //////////////////////////////////////////////////////////////////////
    // input side and host commands

    pixel_input u_pixel_input (
        .core_clk      (core_clk),
        .sys_reset     (sys_reset),
        .cam_plus_d_i  (cam_plus_d_i),
        .cam_minus_d_i (cam_minus_d_i),
        .cam_valid_i   (cam_valid_i),
        .cam_sof_i     (cam_sof_i),
        .pix_o         (pix_bus)
    );

    command_decoder u_command_decoder (
        .core_clk    (core_clk),
        .sys_reset   (sys_reset),
        .cmd_byte_i  (cmd_byte_i),
        .cmd_valid_i (cmd_valid_i),
        .coeff_o     (coeff_bus)
    );

    //////////////////////////////////////////////////////////////////////
    // blend and output framing

    disparity_blend u_disparity_blend (
        .core_clk  (core_clk),
        .sys_reset (sys_reset),
        .pix_i     (pix_bus),
        .coeff_i   (coeff_bus),
        .depth_o   (depth_bus)
    );

    frame_packer u_frame_packer (
        .core_clk   (core_clk),
        .sys_reset  (sys_reset),
        .depth_i    (depth_bus),
        .tx_byte_o  (tx_byte_o),
        .tx_valid_o (tx_valid_o),
        .overflow_o (overflow_o)
    );

endmodule

`default_nettype wire

/* frame_packer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "stereo_config.svh"

module frame_packer (
    input  logic               core_clk,
    input  logic               sys_reset,
    depth_stream_if.sink       depth_i,
    output stereo_pkg::pixel_t tx_byte_o,
    output logic               tx_valid_o,
    output logic               overflow_o
);
    import stereo_pkg::*;

    localparam int          DEPTH = `STEREO_FIFO_DEPTH;
    localparam int          PTR_W = $clog2(DEPTH);
    localparam int          HDR_W = $clog2(`STEREO_HEADER_BYTES);
    localparam logic [63:0] MAGIC = `STEREO_MAGIC;

    // entry is {frame start mark, byte}
    logic [8:0]       fifo_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   fifo_count;
    logic             fifo_empty;
    logic             fifo_full;
    logic             fifo_push;
    logic             fifo_pop;
    logic             frame_start;
    logic             head_sof;
    pixel_t           head_byte;

    pack_state_t      state;
    logic [HDR_W-1:0] hdr_idx;
    logic             hdr_sent;
    logic             hdr_begin;
    pixel_t           hdr_byte;

    assign frame_start = (depth_i.row == '0) && (depth_i.col == '0);
    assign fifo_empty  = (fifo_count == '0);
    assign fifo_full   = (fifo_count == (PTR_W + 1)'(DEPTH));
    assign fifo_push   = depth_i.valid && !fifo_full;
    assign {head_sof, head_byte} = fifo_mem[rd_ptr];

    // a marked byte at the head waits until its header is out
    assign hdr_begin = (state == PACK_IDLE) && !fifo_empty && head_sof && !hdr_sent;
    assign fifo_pop  = (state == PACK_IDLE) && !fifo_empty && !hdr_begin;
    assign hdr_byte  = MAGIC[63 - 8 * hdr_idx -: 8];

    //////////////////////////////////////////////////////////////////////
    // pixel fifo

    always_ff @(posedge core_clk) begin
        if (fifo_push) begin
            fifo_mem[wr_ptr] <= {frame_start, depth_i.depth};
        end
    end

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (fifo_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (fifo_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({fifo_push, fifo_pop})
                2'b10:   fifo_count <= fifo_count + 1'b1;
                2'b01:   fifo_count <= fifo_count - 1'b1;
                default: fifo_count <= fifo_count;
            endcase
            // byte lost, flag holds until reset
            if (depth_i.valid && fifo_full) begin
                overflow_o <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // header insertion

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            state    <= PACK_IDLE;
            hdr_idx  <= '0;
            hdr_sent <= 1'b0;
        end else begin
            case (state)
                PACK_IDLE: begin
                    if (hdr_begin) begin
                        state   <= PACK_HEADER;
                        hdr_idx <= hdr_idx + 1'b1;
                    end
                end
                PACK_HEADER: begin
                    if (hdr_idx == HDR_W'(`STEREO_HEADER_BYTES - 1)) begin
                        state    <= PACK_IDLE;
                        hdr_idx  <= '0;
                        hdr_sent <= 1'b1;
                    end else begin
                        hdr_idx <= hdr_idx + 1'b1;
                    end
                end
                default: state <= PACK_IDLE;
            endcase
            if (fifo_pop) begin
                hdr_sent <= 1'b0;
            end
        end
    end

    // header byte zero goes out in the same cycle the marked byte shows up
    always_comb begin
        tx_valid_o = 1'b0;
        tx_byte_o  = head_byte;
        if (state == PACK_HEADER || hdr_begin) begin
            tx_valid_o = 1'b1;
            tx_byte_o  = hdr_byte;
        end else if (fifo_pop) begin
            tx_valid_o = 1'b1;
        end
    end

    // pointers meet only when the fifo is empty or full
    a_no_pop_empty: assert property (@(posedge core_clk) disable iff (sys_reset)
        fifo_pop |-> (wr_ptr != rd_ptr) || fifo_full)
        else $error("fifo popped while empty");

    a_overflow_sticky: assert property (@(posedge core_clk) disable iff (sys_reset)
        overflow_o |=> overflow_o)
        else $error("overflow flag fell without reset");

endmodule

`default_nettype wire

/* disparity_blend.sv */
`timescale 1ns/1ps
`default_nettype none

module disparity_blend (
    input  logic           core_clk,
    input  logic           sys_reset,
    pixel_pair_if.sink     pix_i,
    blend_coeff_if.sink    coeff_i,
    depth_stream_if.source depth_o
);
    import stereo_pkg::*;

    logic [15:0] prod_plus;
    logic [15:0] prod_minus;

    // stage one registers
    logic               valid_q;
    logic signed [17:0] diff_q;
    coord_t             row_q;
    coord_t             col_q;

    logic signed [17:0] shifted;
    logic signed [18:0] biased;
    pixel_t             depth_next;

    //////////////////////////////////////////////////////////////////////
    // stage one, weighted difference

    always_comb begin
        prod_plus  = pix_i.px_plus * coeff_i.w_plus;
        prod_minus = pix_i.px_minus * coeff_i.w_minus;
    end

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= pix_i.valid;
        end
    end

    always_ff @(posedge core_clk) begin
        diff_q <= $signed({2'b00, prod_plus}) - $signed({2'b00, prod_minus});
        row_q  <= pix_i.row;
        col_q  <= pix_i.col;
    end

    //////////////////////////////////////////////////////////////////////
    // stage two, shift, offset and clamp

    always_comb begin
        shifted = diff_q >>> coeff_i.shift;
        biased  = {shifted[17], shifted} + {{3{coeff_i.offset[15]}}, coeff_i.offset};

        if (biased < 0) begin
            depth_next = '0;
        end else if (biased > 19'sd255) begin
            depth_next = 8'hFF;
        end else begin
            depth_next = biased[7:0];
        end
    end

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            depth_o.valid <= 1'b0;
        end else begin
            depth_o.valid <= valid_q;
        end
    end

    always_ff @(posedge core_clk) begin
        depth_o.depth <= depth_next;
        depth_o.row   <= row_q;
        depth_o.col   <= col_q;
    end

endmodule

`default_nettype wire

/* command_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "stereo_config.svh"

module command_decoder (
    input  logic               core_clk,
    input  logic               sys_reset,
    input  stereo_pkg::pixel_t cmd_byte_i,
    input  logic               cmd_valid_i,
    blend_coeff_if.source      coeff_o
);
    import stereo_pkg::*;

    localparam logic [2:0] LAST_BYTE = 3'd5;

    logic [2:0]  byte_cnt;
    // first five bytes of a command, oldest in the top byte
    logic [39:0] byte_shift;

    cmd_addr_t cmd_addr;
    cmd_data_t cmd_data;
    logic      cmd_done;

    // sixth byte completes the word straight from the input
    assign {cmd_addr, cmd_data} = {byte_shift, cmd_byte_i};
    assign cmd_done = cmd_valid_i && (byte_cnt == LAST_BYTE);

    //////////////////////////////////////////////////////////////////////
    // byte collection

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            byte_cnt <= '0;
        end else if (cmd_valid_i) begin
            byte_cnt <= (byte_cnt == LAST_BYTE) ? '0 : byte_cnt + 1'b1;
        end
    end

    always_ff @(posedge core_clk) begin
        if (cmd_valid_i) begin
            byte_shift <= {byte_shift[31:0], cmd_byte_i};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // coefficient registers

    // defaults pass the plus pixel straight through
    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            coeff_o.w_plus  <= weight_t'(1);
            coeff_o.w_minus <= '0;
            coeff_o.shift   <= '0;
            coeff_o.offset  <= '0;
        end else if (cmd_done) begin
            case (cmd_addr)
                `STEREO_ADDR_W_PLUS:  coeff_o.w_plus  <= cmd_data[7:0];
                `STEREO_ADDR_W_MINUS: coeff_o.w_minus <= cmd_data[7:0];
                `STEREO_ADDR_SHIFT:   coeff_o.shift   <= cmd_data[3:0];
                `STEREO_ADDR_OFFSET:  coeff_o.offset  <= cmd_data[15:0];
                // unknown address, nothing changes
                default: ;
            endcase
        end
    end

    a_byte_cnt_range: assert property (@(posedge core_clk) disable iff (sys_reset)
        byte_cnt < 3'd6)
        else $error("command byte counter out of range");

endmodule

`default_nettype wire

/* pixel_input.sv */
`timescale 1ns/1ps
`default_nettype none

`include "stereo_config.svh"

module pixel_input (
    input  logic               core_clk,
    input  logic               sys_reset,
    input  stereo_pkg::pixel_t cam_plus_d_i,
    input  stereo_pkg::pixel_t cam_minus_d_i,
    input  logic               cam_valid_i,
    input  logic               cam_sof_i,
    pixel_pair_if.source       pix_o
);
    import stereo_pkg::*;

    localparam coord_t LAST_COL = coord_t'(`STEREO_ROI_WIDTH - 1);
    localparam coord_t LAST_ROW = coord_t'(`STEREO_ROI_HEIGHT - 1);

    // position of the next expected pixel
    coord_t col_cnt;
    coord_t row_cnt;

    // position of the pixel on the input this cycle
    coord_t cur_col;
    coord_t cur_row;
    coord_t next_col;
    coord_t next_row;

    //////////////////////////////////////////////////////////////////////
    // roi position tracking

    always_comb begin
        // sof restarts the frame wherever the counters are
        cur_col = cam_sof_i ? '0 : col_cnt;
        cur_row = cam_sof_i ? '0 : row_cnt;

        if (cur_col == LAST_COL) begin
            next_col = '0;
            next_row = (cur_row == LAST_ROW) ? '0 : cur_row + 1'b1;
        end else begin
            next_col = cur_col + 1'b1;
            next_row = cur_row;
        end
    end

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            col_cnt     <= '0;
            row_cnt     <= '0;
            pix_o.valid <= 1'b0;
        end else begin
            pix_o.valid <= cam_valid_i;
            if (cam_valid_i) begin
                col_cnt <= next_col;
                row_cnt <= next_row;
            end
        end
    end

    // pixel pair and coordinates, one cycle behind the camera
    always_ff @(posedge core_clk) begin
        if (cam_valid_i) begin
            pix_o.px_plus  <= cam_plus_d_i;
            pix_o.px_minus <= cam_minus_d_i;
            pix_o.row      <= cur_row;
            pix_o.col      <= cur_col;
        end
    end

    // every pixel leaving this stage lies inside the roi width
    a_col_in_roi: assert property (@(posedge core_clk) disable iff (sys_reset)
        pix_o.valid |-> pix_o.col < coord_t'(`STEREO_ROI_WIDTH))
        else $error("pixel column outside roi");

endmodule

`default_nettype wire

/* pipeline_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

// registered camera pair with its roi position
interface pixel_pair_if;
    import stereo_pkg::*;

    logic   valid;
    coord_t row;
    coord_t col;
    pixel_t px_plus;
    pixel_t px_minus;

    modport source (output valid, row, col, px_plus, px_minus);
    modport sink   (input  valid, row, col, px_plus, px_minus);
endinterface

// one blended byte per strobe
interface depth_stream_if;
    import stereo_pkg::*;

    logic   valid;
    coord_t row;
    coord_t col;
    pixel_t depth;

    modport source (output valid, row, col, depth);
    modport sink   (input  valid, row, col, depth);
endinterface

// coefficient levels, held until the host rewrites them
interface blend_coeff_if;
    import stereo_pkg::*;

    weight_t w_plus;
    weight_t w_minus;
    shift_t  shift;
    offset_t offset;

    modport source (output w_plus, w_minus, shift, offset);
    modport sink   (input  w_plus, w_minus, shift, offset);
endinterface

`default_nettype wire

/* stereo_pkg.sv */
`default_nettype none

package stereo_pkg;

    //////////////////////////////////////////////////////////////////////
    // data path widths

    // one camera pixel, also one byte on the host link
    typedef logic [7:0] pixel_t;

    // row or column index inside the roi
    typedef logic [15:0] coord_t;

    //////////////////////////////////////////////////////////////////////
    // blend coefficients

    typedef logic [7:0] weight_t;
    typedef logic [3:0] shift_t;
    typedef logic signed [15:0] offset_t;

    //////////////////////////////////////////////////////////////////////
    // host commands

    typedef logic [15:0] cmd_addr_t;
    typedef logic [31:0] cmd_data_t;

    // output framing
    typedef enum logic {
        PACK_IDLE,
        PACK_HEADER
    } pack_state_t;

endpackage

`default_nettype wire

/* stereo_config.svh */
`ifndef STEREO_CONFIG_SVH
`define STEREO_CONFIG_SVH

// region of interest seen by the blend path
`define STEREO_ROI_WIDTH    8
`define STEREO_ROI_HEIGHT   4

// packer fifo entries
`define STEREO_FIFO_DEPTH   16

// frame header, sent first byte first
`define STEREO_HEADER_BYTES 8
// B I V F R A M E
`define STEREO_MAGIC        64'h42_49_56_46_52_41_4D_45

// host command addresses for the blend coefficients
`define STEREO_ADDR_W_PLUS  16'h0010
`define STEREO_ADDR_W_MINUS 16'h0011
`define STEREO_ADDR_SHIFT   16'h0012
`define STEREO_ADDR_OFFSET  16'h0013

`endif
